//--- rtl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int RAM_ADDR_W = 8;              // word address, 256 words
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;

    // memory operation carried down the pipe, op_none is a plain alu result
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lw   = 4'd1,
        op_lb   = 4'd2,
        op_lbu  = 4'd3,
        op_lh   = 4'd4,
        op_lhu  = 4'd5,
        op_lwl  = 4'd6,
        op_lwr  = 4'd7,
        op_sw   = 4'd8,
        op_sb   = 4'd9,
        op_sh   = 4'd10,
        op_swl  = 4'd11,
        op_swr  = 4'd12
    } mem_op_t;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t exc_none = 5'd0;
    localparam exc_code_t exc_adel = 5'd4;      // load address error
    localparam exc_code_t exc_ades = 5'd5;      // store address error

    function automatic logic is_load(mem_op_t op);
        return op inside {op_lw, op_lb, op_lbu, op_lh, op_lhu, op_lwl, op_lwr};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {op_sw, op_sb, op_sh, op_swl, op_swr};
    endfunction

    // halfword accesses need an even address
    function automatic logic is_half(mem_op_t op);
        return op inside {op_lh, op_lhu, op_sh};
    endfunction

    // only lw and sw need full word alignment, lwl/lwr/swl/swr never fault
    function automatic logic is_word(mem_op_t op);
        return op inside {op_lw, op_sw};
    endfunction

endpackage

`default_nettype wire

//--- rtl/es_stage.sv
`timescale 1ns/100ps
`default_nettype none

module es_stage import mips_mem_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // upstream handshake and payload
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire mem_op_t               in_op,
    input  wire logic [DATA_W-1:0]     in_alu_result,
    input  wire logic [DATA_W-1:0]     in_rt_value,
    input  wire logic [REG_ADDR_W-1:0] in_dest,
    input  wire logic                  in_gr_we,
    input  wire logic [DATA_W-1:0]     in_pc,
    input  wire logic                  in_ex,
    input  wire exc_code_t             in_exc_code,
    // older stages
    input  wire logic                  ms_allowin,
    input  wire logic                  ms_ex,
    input  wire logic                  ws_ex,
    input  wire logic                  flush,
    // to mem_stage
    output logic                       es_to_ms_valid,
    output mem_op_t                    es_to_ms_op,
    output logic [DATA_W-1:0]          es_to_ms_alu_result,
    output logic [DATA_W-1:0]          es_to_ms_rt_value,
    output logic [REG_ADDR_W-1:0]      es_to_ms_dest,
    output logic                       es_to_ms_gr_we,
    output logic [DATA_W-1:0]          es_to_ms_pc,
    output logic                       es_to_ms_ex,
    output exc_code_t                  es_to_ms_exc_code,
    // data ram request
    output logic                       sram_en,
    output logic [3:0]                 sram_wen,
    output logic [RAM_ADDR_W-1:0]      sram_addr,
    output logic [DATA_W-1:0]          sram_wdata
);

    logic              es_valid;
    logic              es_allowin;
    logic              in_addr_err;
    logic              store_block;
    logic [1:0]        lane;
    logic [3:0]        store_wen;
    logic [DATA_W-1:0] store_wdata;

    assign es_allowin     = !es_valid || ms_allowin;
    assign in_ready       = es_allowin && !flush;
    assign es_to_ms_valid = es_valid;

    // alignment check on the incoming address
    assign in_addr_err = (is_half(in_op) && in_alu_result[0])
                      || (is_word(in_op) && in_alu_result[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            es_to_ms_op         <= in_op;
            es_to_ms_alu_result <= in_alu_result;
            es_to_ms_rt_value   <= in_rt_value;
            es_to_ms_dest       <= in_dest;
            es_to_ms_gr_we      <= in_gr_we;
            es_to_ms_pc         <= in_pc;
            es_to_ms_ex         <= in_ex || in_addr_err;
            if (in_ex) begin
                es_to_ms_exc_code <= in_exc_code;   // upstream exception wins
            end else if (in_addr_err) begin
                es_to_ms_exc_code <= is_store(in_op) ? exc_ades : exc_adel;
            end else begin
                es_to_ms_exc_code <= exc_none;
            end
        end
    end

    assign lane = es_to_ms_alu_result[1:0];

    // little endian byte lanes
    always_comb begin
        store_wen   = 4'b0000;
        store_wdata = es_to_ms_rt_value;
        case (es_to_ms_op)
            op_sb: begin
                store_wen   = 4'b0001 << lane;
                store_wdata = {4{es_to_ms_rt_value[7:0]}};
            end
            op_sh: begin
                store_wen   = lane[1] ? 4'b1100 : 4'b0011;
                store_wdata = {2{es_to_ms_rt_value[15:0]}};
            end
            op_sw: store_wen = 4'b1111;
            op_swl: begin                               // high bytes of rt to low lanes
                store_wen   = 4'b1111 >> ~lane;
                store_wdata = es_to_ms_rt_value >> {~lane, 3'b000};
            end
            op_swr: begin
                store_wen   = 4'b1111 << lane;
                store_wdata = es_to_ms_rt_value << {lane, 3'b000};
            end
            default: store_wen = 4'b0000;
        endcase
    end

    // an older excepting op in ms or wb kills the store
    assign store_block = es_to_ms_ex || ms_ex || ws_ex;

    assign sram_en    = es_valid && ms_allowin && !flush;
    assign sram_wen   = (sram_en && !store_block) ? store_wen : 4'b0000;
    assign sram_addr  = es_to_ms_alu_result[RAM_ADDR_W+1:2];
    assign sram_wdata = store_wdata;

    // no write from an excepting op, nor in the cycle wb retires an exception
    a_no_bad_write: assert property (@(posedge clk) disable iff (reset)
        (sram_wen != 4'b0000) |-> (!es_to_ms_ex && !flush));

endmodule

`default_nettype wire

//--- rtl/data_sram.sv
`timescale 1ns/100ps
`default_nettype none

module data_sram import mips_mem_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  en,
    input  wire logic [3:0]            wen,
    input  wire logic [RAM_ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]          rdata
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (wen[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];     // old data on a write
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage import mips_mem_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // from es_stage
    input  wire logic                  es_to_ms_valid,
    output logic                       ms_allowin,
    input  wire mem_op_t               es_to_ms_op,
    input  wire logic [DATA_W-1:0]     es_to_ms_alu_result,
    input  wire logic [DATA_W-1:0]     es_to_ms_rt_value,
    input  wire logic [REG_ADDR_W-1:0] es_to_ms_dest,
    input  wire logic                  es_to_ms_gr_we,
    input  wire logic [DATA_W-1:0]     es_to_ms_pc,
    input  wire logic                  es_to_ms_ex,
    input  wire exc_code_t             es_to_ms_exc_code,
    // held ram read data
    input  wire logic [DATA_W-1:0]     data_rdata,
    input  wire logic                  ws_allowin,
    input  wire logic                  flush,
    output logic                       ms_ex,
    // to wb_stage
    output logic                       ms_to_ws_valid,
    output logic [DATA_W-1:0]          ms_to_ws_pc,
    output logic [REG_ADDR_W-1:0]      ms_to_ws_dest,
    output logic                       ms_to_ws_gr_we,
    output logic [DATA_W-1:0]          ms_to_ws_result,
    output logic                       ms_to_ws_ex,
    output exc_code_t                  ms_to_ws_exc_code
);

    logic              ms_valid;
    mem_op_t           ms_op;
    logic [DATA_W-1:0] ms_alu_result;
    logic [DATA_W-1:0] ms_rt_value;
    logic              ms_gr_we;
    logic [1:0]        lane;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    logic [DATA_W-1:0] merge_lwl;
    logic [DATA_W-1:0] merge_lwr;
    logic [DATA_W-1:0] load_data;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;
    assign ms_ex          = ms_valid && ms_to_ws_ex;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_op             <= es_to_ms_op;
            ms_alu_result     <= es_to_ms_alu_result;
            ms_rt_value       <= es_to_ms_rt_value;
            ms_gr_we          <= es_to_ms_gr_we;
            ms_to_ws_pc       <= es_to_ms_pc;
            ms_to_ws_dest     <= es_to_ms_dest;
            ms_to_ws_ex       <= es_to_ms_ex;
            ms_to_ws_exc_code <= es_to_ms_exc_code;
        end
    end

    assign lane = ms_alu_result[1:0];

    always_comb begin
        case (lane)
            2'd0:    load_byte = data_rdata[7:0];
            2'd1:    load_byte = data_rdata[15:8];
            2'd2:    load_byte = data_rdata[23:16];
            default: load_byte = data_rdata[31:24];
        endcase
    end

    assign load_half = lane[1] ? data_rdata[31:16] : data_rdata[15:0];

    // lwl fills rt from the top, lwr from the bottom
    assign merge_lwl = (lane == 2'd0) ? {data_rdata[7:0],  ms_rt_value[23:0]} :
                       (lane == 2'd1) ? {data_rdata[15:0], ms_rt_value[15:0]} :
                       (lane == 2'd2) ? {data_rdata[23:0], ms_rt_value[7:0]}  :
                                        data_rdata;
    assign merge_lwr = (lane == 2'd0) ? data_rdata :
                       (lane == 2'd1) ? {ms_rt_value[31:24], data_rdata[31:8]}  :
                       (lane == 2'd2) ? {ms_rt_value[31:16], data_rdata[31:16]} :
                                        {ms_rt_value[31:8],  data_rdata[31:24]};

    always_comb begin
        case (ms_op)
            op_lb:   load_data = {{24{load_byte[7]}}, load_byte};
            op_lbu:  load_data = {24'd0, load_byte};
            op_lh:   load_data = {{16{load_half[15]}}, load_half};
            op_lhu:  load_data = {16'd0, load_half};
            op_lwl:  load_data = merge_lwl;
            op_lwr:  load_data = merge_lwr;
            default: load_data = data_rdata;        // lw
        endcase
    end

    assign ms_to_ws_result = is_load(ms_op) ? load_data : ms_alu_result;
    assign ms_to_ws_gr_we  = ms_gr_we && !ms_to_ws_ex;   // no rf write on exception

    // flushed ops must not reach wb
    a_flush_kills_ms: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ms_to_ws_valid);

endmodule

`default_nettype wire

//--- rtl/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage import mips_mem_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // from mem_stage
    input  wire logic                  ms_to_ws_valid,
    output logic                       ws_allowin,
    input  wire logic [DATA_W-1:0]     ms_to_ws_pc,
    input  wire logic [REG_ADDR_W-1:0] ms_to_ws_dest,
    input  wire logic                  ms_to_ws_gr_we,
    input  wire logic [DATA_W-1:0]     ms_to_ws_result,
    input  wire logic                  ms_to_ws_ex,
    input  wire exc_code_t             ms_to_ws_exc_code,
    output logic                       ws_ex,
    output logic                       flush,
    // commit ports
    output logic                       commit_valid,
    input  wire logic                  commit_ready,
    output logic [DATA_W-1:0]          commit_pc,
    output logic [REG_ADDR_W-1:0]      commit_dest,
    output logic                       commit_we,
    output logic [DATA_W-1:0]          commit_data,
    output logic                       commit_ex,
    output exc_code_t                  commit_exc_code
);

    logic ws_valid;

    assign ws_allowin   = !ws_valid || commit_ready;
    assign commit_valid = ws_valid;
    assign ws_ex        = ws_valid && commit_ex;
    assign flush        = ws_ex && commit_ready;    // excepting entry retires

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid && !flush;   // younger op dies with the flush
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            commit_pc       <= ms_to_ws_pc;
            commit_dest     <= ms_to_ws_dest;
            commit_we       <= ms_to_ws_gr_we;
            commit_data     <= ms_to_ws_result;
            commit_ex       <= ms_to_ws_ex;
            commit_exc_code <= ms_to_ws_exc_code;
        end
    end

    a_commit_hold: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid
            && $stable({commit_pc, commit_dest, commit_we, commit_data,
                        commit_ex, commit_exc_code})));

endmodule

`default_nettype wire

//--- rtl/mem_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_top import mips_mem_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire mem_op_t               in_op,
    input  wire logic [DATA_W-1:0]     in_alu_result,
    input  wire logic [DATA_W-1:0]     in_rt_value,
    input  wire logic [REG_ADDR_W-1:0] in_dest,
    input  wire logic                  in_gr_we,
    input  wire logic [DATA_W-1:0]     in_pc,
    input  wire logic                  in_ex,
    input  wire exc_code_t             in_exc_code,
    output logic                       commit_valid,
    input  wire logic                  commit_ready,
    output logic [DATA_W-1:0]          commit_pc,
    output logic [REG_ADDR_W-1:0]      commit_dest,
    output logic                       commit_we,
    output logic [DATA_W-1:0]          commit_data,
    output logic                       commit_ex,
    output exc_code_t                  commit_exc_code
);

    // es -> ms
    logic                  es_to_ms_valid;
    logic                  ms_allowin;
    mem_op_t               es_to_ms_op;
    logic [DATA_W-1:0]     es_to_ms_alu_result;
    logic [DATA_W-1:0]     es_to_ms_rt_value;
    logic [REG_ADDR_W-1:0] es_to_ms_dest;
    logic                  es_to_ms_gr_we;
    logic [DATA_W-1:0]     es_to_ms_pc;
    logic                  es_to_ms_ex;
    exc_code_t             es_to_ms_exc_code;
    // ms -> ws
    logic                  ms_to_ws_valid;
    logic                  ws_allowin;
    logic [DATA_W-1:0]     ms_to_ws_pc;
    logic [REG_ADDR_W-1:0] ms_to_ws_dest;
    logic                  ms_to_ws_gr_we;
    logic [DATA_W-1:0]     ms_to_ws_result;
    logic                  ms_to_ws_ex;
    exc_code_t             ms_to_ws_exc_code;
    // exception feedback and ram
    logic                  ms_ex;
    logic                  ws_ex;
    logic                  flush;
    logic                  sram_en;
    logic [3:0]            sram_wen;
    logic [RAM_ADDR_W-1:0] sram_addr;
    logic [DATA_W-1:0]     sram_wdata;
    logic [DATA_W-1:0]     sram_rdata;

    es_stage u_es (.*);

    data_sram u_sram (
        .clk   (clk),
        .en    (sram_en),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    mem_stage u_ms (.*, .data_rdata(sram_rdata));

    wb_stage u_ws (.*);

endmodule

`default_nettype wire

//--- dv/mem_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_tb import mips_mem_pkg::*; ();

    localparam int          NUM_OPS      = 2000;
    localparam int          LAT_OPS      = 8;
    localparam int          WIN_WORDS    = 16;     // small window so loads hit recent stores
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] BASE         = 32'h0000_0200;
    localparam int          TIMEOUT      = RESET_CYCLES + 20 * (NUM_OPS + 2 * WIN_WORDS + LAT_OPS);

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        we;
        logic [31:0] data;
        logic        ex;
        logic [4:0]  code;
        logic        isolated;     // accepted into an empty pipe for the latency check
        logic [31:0] accept_cycle;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    mem_op_t               in_op;
    logic [DATA_W-1:0]     in_alu_result;
    logic [DATA_W-1:0]     in_rt_value;
    logic [REG_ADDR_W-1:0] in_dest;
    logic                  in_gr_we;
    logic [DATA_W-1:0]     in_pc;
    logic                  in_ex;
    exc_code_t             in_exc_code;
    logic                  commit_valid;
    logic                  commit_ready;
    logic [DATA_W-1:0]     commit_pc;
    logic [REG_ADDR_W-1:0] commit_dest;
    logic                  commit_we;
    logic [DATA_W-1:0]     commit_data;
    logic                  commit_ex;
    exc_code_t             commit_exc_code;

    int          seed;
    int          cycle_count;
    int          op_count;
    int          lat_checked;
    logic        hold_ready;
    logic        ready_next;
    logic        latency_mode;
    logic        hold_seen;
    logic [31:0] held_pc;
    logic [31:0] held_data;
    logic [11:0] held_rest;
    logic [31:0] model_mem [RAM_DEPTH];
    expect_t     exp_q [$];

    mem_pipe_top i_mem_pipe_top (.*);

    always #50 clk = ~clk;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("ERROR @ %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display(">>> FAIL");
            $fatal;
        end
    endtask

    function automatic logic reads_memory(mem_op_t op);
        return op == op_lw || op == op_lb || op == op_lbu || op == op_lh || op == op_lhu
            || op == op_lwl || op == op_lwr;
    endfunction

    function automatic logic writes_memory(mem_op_t op);
        return op == op_sw || op == op_sb || op == op_sh || op == op_swl || op == op_swr;
    endfunction

    function automatic logic misaligned(mem_op_t op, logic [1:0] low);
        if (op == op_lh || op == op_lhu || op == op_sh) begin
            return low[0];
        end
        return (op == op_lw || op == op_sw) && low != 2'b00;
    endfunction

    // address dependent preload value
    function automatic logic [31:0] fill_word(logic [7:0] a);
        return {a ^ 8'h5a, ~a, a * 8'd29, a + 8'hc3};
    endfunction

    // byte wise little endian load where lwl/lwr keep the untouched rt bytes
    function automatic logic [31:0] load_value(mem_op_t op, logic [31:0] word, logic [1:0] k,
                                               logic [31:0] rt);
        logic [31:0] v;
        v = rt;
        case (op)
            op_lb:  v = {{24{word[8*k+7]}}, word[8*k +: 8]};
            op_lbu: v = {24'd0, word[8*k +: 8]};
            op_lh:  v = {{16{word[16*k[1]+15]}}, word[16*k[1] +: 16]};
            op_lhu: v = {16'd0, word[16*k[1] +: 16]};
            op_lwl: for (int b = 0; b <= k; b++) v[8*(3-k+b) +: 8] = word[8*b +: 8];
            op_lwr: for (int b = k; b < 4; b++) v[8*(b-k) +: 8] = word[8*b +: 8];
            default: v = word;
        endcase
        return v;
    endfunction

    task automatic apply_store(mem_op_t op, logic [31:0] addr, logic [31:0] rt);
        logic [7:0] w;
        logic [1:0] k;
        w = addr[9:2];
        k = addr[1:0];
        case (op)
            op_sb:  model_mem[w][8*k +: 8] = rt[7:0];
            op_sh:  model_mem[w][16*k[1] +: 16] = rt[15:0];
            op_swl: for (int b = 0; b <= k; b++) model_mem[w][8*b +: 8] = rt[8*(3-k+b) +: 8];
            op_swr: for (int b = k; b < 4; b++) model_mem[w][8*b +: 8] = rt[8*(b-k) +: 8];
            default: model_mem[w] = rt;   // sw
        endcase
    endtask

    task automatic record_accept();
        expect_t e;
        logic    addr_err;
        logic    older_ex;
        addr_err = misaligned(in_op, in_alu_result[1:0]);
        older_ex = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].ex) older_ex = 1'b1;
        end
        e.pc   = in_pc;
        e.dest = in_dest;
        e.ex   = in_ex || addr_err;
        if (in_ex) begin
            e.code = in_exc_code;
        end else if (addr_err) begin
            e.code = writes_memory(in_op) ? exc_ades : exc_adel;
        end else begin
            e.code = exc_none;
        end
        e.we = in_gr_we && !e.ex;
        if (reads_memory(in_op)) begin
            e.data = load_value(in_op, model_mem[in_alu_result[9:2]], in_alu_result[1:0],
                                in_rt_value);
        end else begin
            e.data = in_alu_result;
        end
        // stores behind an excepting op are flushed before they write
        if (writes_memory(in_op) && !e.ex && !older_ex) begin
            apply_store(in_op, in_alu_result, in_rt_value);
        end
        e.isolated     = latency_mode && exp_q.size() == 0;
        e.accept_cycle = cycle_count;
        exp_q.push_back(e);
    endtask

    task automatic retire_entry();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("commit of pc %h at %0t ns with no operation outstanding",
                     commit_pc, $time);
            $display(">>> FAIL");
            $fatal;
        end
        e = exp_q.pop_front();
        check_equal(commit_pc, e.pc, "commit_pc");
        check_equal(32'(commit_ex), 32'(e.ex), "commit_ex");
        check_equal(32'(commit_exc_code), 32'(e.code), "commit_exc_code");
        check_equal(32'(commit_we), 32'(e.we), "commit_we");
        check_equal(32'(commit_dest), 32'(e.dest), "commit_dest");
        if (!e.ex) check_equal(commit_data, e.data, "commit_data");
        if (e.isolated) begin
            check_equal(cycle_count - e.accept_cycle, 32'd3, "accept to commit cycles");
            lat_checked++;
        end
        if (e.ex) exp_q.delete();   // everything younger dies with the flush
    endtask

    task automatic send_op(input mem_op_t op, input logic [31:0] addr, input logic [31:0] rt,
                           input logic ex, input logic [4:0] code);
        logic [31:0] r;
        logic        taken;
        r             = $random(seed);
        in_valid      = 1'b1;
        in_op         = op;
        in_alu_result = addr;
        in_rt_value   = rt;
        in_dest       = r[4:0];
        in_gr_we      = r[5];
        in_pc         = {r[31:16], 14'(op_count), 2'b00};
        in_ex         = ex;
        in_exc_code   = code;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        op_count++;
    endtask

    task automatic send_random_op();
        logic [31:0] r;
        logic [31:0] addr;
        mem_op_t     op;
        logic [1:0]  lane;
        r    = $random(seed);
        op   = mem_op_t'(4'(r % 13));
        r    = $random(seed);
        lane = r[5:4];
        if (r[10:8] != 3'd0) begin      // mostly naturally aligned
            if (op == op_lw || op == op_sw) lane = 2'd0;
            if (op == op_lh || op == op_lhu || op == op_sh) lane[0] = 1'b0;
        end
        addr = (op == op_none) ? $random(seed) : {BASE[31:6], r[3:0], lane};
        send_op(op, addr, $random(seed), r[15:12] == 4'd0, r[20:16]);
        if (r[24]) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // next stall decision drawn mid cycle
    always @(negedge clk) begin : draw_ready
        logic [31:0] rr;
        rr         = $random(seed);
        ready_next = hold_ready || (rr % 10) >= 3;     // about 30 percent stall
    end

    always @(posedge clk) begin : drive_ready
        #1;
        commit_ready = ready_next;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display(">>> FAIL");
            $fatal;
        end
    end

    // handshakes seen mid cycle complete at the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (hold_seen) begin
                check_equal(32'(commit_valid), 32'd1, "commit_valid while stalled");
                check_equal(commit_pc, held_pc, "commit_pc while stalled");
                check_equal(commit_data, held_data, "commit_data while stalled");
                check_equal(32'({commit_dest, commit_we, commit_ex, commit_exc_code}),
                            32'(held_rest), "commit fields while stalled");
            end
            if (commit_valid && commit_ready) retire_entry();
            if (in_valid && in_ready) record_accept();
            hold_seen = commit_valid && !commit_ready;
            held_pc   = commit_pc;
            held_data = commit_data;
            held_rest = {commit_dest, commit_we, commit_ex, commit_exc_code};
        end
    end

    initial begin
        seed          = 64;
        cycle_count   = 0;
        op_count      = 0;
        lat_checked   = 0;
        hold_ready    = 1'b0;
        ready_next    = 1'b0;
        latency_mode  = 1'b0;
        hold_seen     = 1'b0;
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = op_none;
        in_alu_result = '0;
        in_rt_value   = '0;
        in_dest       = '0;
        in_gr_we      = 1'b0;
        in_pc         = '0;
        in_ex         = 1'b0;
        in_exc_code   = exc_none;
        commit_ready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_equal(32'(in_ready), 32'd1, "in_ready after reset");
        check_equal(32'(commit_valid), 32'd0, "commit_valid after reset");
        @(posedge clk);
        #1;
        for (int w = 0; w < WIN_WORDS; w++) begin
            send_op(op_sw, {BASE[31:6], 4'(w), 2'b00}, fill_word(BASE[9:2] + 8'(w)), 1'b0, 5'd0);
        end
        repeat (NUM_OPS) send_random_op();
        for (int w = 0; w < WIN_WORDS; w++) begin   // read back the whole window
            send_op(op_lw, {BASE[31:6], 4'(w), 2'b00}, 32'd0, 1'b0, 5'd0);
        end
        hold_ready   = 1'b1;
        latency_mode = 1'b1;
        @(posedge clk);
        #1;
        repeat (LAT_OPS) begin
            wait_drain();
            send_random_op();
        end
        wait_drain();
        check_equal(lat_checked, LAT_OPS, "isolated latency checks");
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/mips_mem_pkg.sv
rtl/es_stage.sv
rtl/data_sram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mem_pipe_top.sv
dv/mem_pipe_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_pipe_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
